// File: hdl/uart_pkg.sv
// shared types for the uart; data_t is sized for 8 data bits, unused upper bits stay zero
package uart_pkg;

    typedef logic [7:0] data_t;       // one serial word, lsb sent first
    typedef logic [3:0] bit_count_t;  // bit index inside a frame

    localparam logic MARK  = 1'b1;    // idle and stop level
    localparam logic SPACE = 1'b0;    // start bit level

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // strobes from the receive fsm to the shift register
    typedef struct packed {
        logic sample;  // shift in rxd now
        logic commit;  // frame ended with a good stop bit
        logic clear;   // start of a new frame
    } rx_shift_cmd_t;

    // one-cycle receive error pulses
    typedef struct packed {
        logic frame_error;
        logic overrun;
    } rx_event_t;

endpackage

// File: hdl/uart_bit_timer.sv
// bit period timer; CLKS_PER_BIT must be at least 4, ticks keep running until the next restart
module uart_bit_timer #(
    parameter int unsigned CLKS_PER_BIT = 8
)(
    input  logic clk,
    input  logic resetn,
    input  logic restart,
    input  logic half,
    output logic tick
);

    localparam int unsigned CW = $clog2(CLKS_PER_BIT);

    localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);

    logic [CW-1:0] count;

    // a load of n-1 reaches zero n cycles after the restart cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= FULL_LOAD;
        end else if (restart) begin
            count <= half ? HALF_LOAD : FULL_LOAD;
        end else if (count == '0) begin
            count <= FULL_LOAD;  // free-run at the full period
        end else begin
            count <= count - 1'b1;
        end
    end

    assign tick = (count == '0);

endmodule

// File: hdl/uart_rx_ctrl.sv
// receive fsm; rxd must already be synchronous to clk, only the first stop bit is checked
module uart_rx_ctrl
    import uart_pkg::*;
#(
    parameter int unsigned CLKS_PER_BIT = 8,
    parameter int unsigned DATA_BITS    = 8
)(
    input  logic          clk,
    input  logic          resetn,
    input  logic          rxd,
    output rx_shift_cmd_t cmd,
    output logic          frame_error
);

    localparam bit_count_t LAST_BIT = bit_count_t'(DATA_BITS - 1);

    rx_state_t  state;
    bit_count_t bit_cnt;
    logic       tick;
    logic       start_seen;
    logic       stop_tick;

    assign start_seen = (state == RX_IDLE) && (rxd == SPACE);
    assign stop_tick  = (state == RX_STOP) && tick;

    // first sample lands mid start bit, then one full period per bit
    uart_bit_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_timer (
        .clk    (clk),
        .resetn (resetn),
        .restart(start_seen),
        .half   (state == RX_IDLE),
        .tick   (tick)
    );

    assign cmd.clear  = start_seen;
    assign cmd.sample = (state == RX_DATA) && tick;
    assign cmd.commit = stop_tick && (rxd == MARK);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            frame_error <= 1'b0;
        end else begin
            frame_error <= stop_tick && (rxd == SPACE);
            unique case (state)
                RX_IDLE: begin
                    if (start_seen)
                        state <= RX_START;
                end
                RX_START: begin
                    bit_cnt <= '0;
                    if (tick)
                        state <= (rxd == MARK) ? RX_IDLE : RX_DATA;  // mark here is a glitch
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (tick)
                        state <= RX_IDLE;  // ready for the next start bit right away
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/uart_rx_shift.sv
// receive shift and holding register; a word completing while one is still held is dropped
module uart_rx_shift
    import uart_pkg::*;
#(
    parameter int unsigned DATA_BITS = 8
)(
    input  logic          clk,
    input  logic          resetn,
    input  logic          rxd,
    input  rx_shift_cmd_t cmd,
    input  logic          rx_ready,
    output data_t         rx_data,
    output logic          rx_valid,
    output logic          overrun
);

    logic [DATA_BITS-1:0] shreg;
    logic                 held;

    // bits enter at the top so the first one ends up in bit 0
    always_ff @(posedge clk) begin
        if (cmd.clear)
            shreg <= '0;
        else if (cmd.sample)
            shreg <= {rxd, shreg[DATA_BITS-1:1]};
    end

    // word is still owed to the sink after this cycle
    assign held = rx_valid && !rx_ready;

    always_ff @(posedge clk) begin
        if (cmd.commit && !held)
            rx_data <= data_t'(shreg);  // upper bits zero when DATA_BITS < 8
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            overrun <= cmd.commit && held;
            if (cmd.commit && !held)
                rx_valid <= 1'b1;
            else if (rx_valid && rx_ready)
                rx_valid <= 1'b0;
        end
    end

endmodule

// File: hdl/uart_tx.sv
// transmit serializer; no parity, STOP_BITS of 1 or 2, one idle cycle between back-to-back frames
module uart_tx
    import uart_pkg::*;
#(
    parameter int unsigned CLKS_PER_BIT = 8,
    parameter int unsigned DATA_BITS    = 8,
    parameter int unsigned STOP_BITS    = 1
)(
    input  logic  clk,
    input  logic  resetn,
    input  data_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    output logic  txd
);

    localparam bit_count_t LAST_DATA = bit_count_t'(DATA_BITS - 1);
    localparam bit_count_t LAST_STOP = bit_count_t'(STOP_BITS - 1);

    tx_state_t  state;
    bit_count_t bit_cnt;
    data_t      shreg;
    logic       tick;
    logic       accept;

    assign tx_ready = (state == TX_IDLE);
    assign accept   = tx_valid && tx_ready;

    uart_bit_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_timer (
        .clk    (clk),
        .resetn (resetn),
        .restart(accept),
        .half   (1'b0),
        .tick   (tick)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            txd     <= MARK;
        end else begin
            unique case (state)
                TX_IDLE: begin
                    if (accept) begin
                        state <= TX_START;
                        txd   <= SPACE;
                    end
                end
                TX_START: begin
                    bit_cnt <= '0;
                    if (tick) begin
                        state <= TX_DATA;
                        txd   <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (bit_cnt == LAST_DATA) begin
                            state   <= TX_STOP;
                            bit_cnt <= '0;
                            txd     <= MARK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shreg[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_STOP)
                            state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    txd   <= MARK;
                end
            endcase
        end
    end

    // word is latched on transfer and shifted right as each bit goes out
    always_ff @(posedge clk) begin
        if (accept)
            shreg <= tx_data;
        else if (tick && (state == TX_START || state == TX_DATA))
            shreg <= {1'b0, shreg[7:1]};
    end

endmodule

// File: hdl/uart_top.sv
// uart top level; rxd must be synchronous to clk, no parity, break or flow control
module uart_top
    import uart_pkg::*;
#(
    parameter int unsigned CLKS_PER_BIT = 8,  // at least 4
    parameter int unsigned DATA_BITS    = 8,  // 5 to 8
    parameter int unsigned STOP_BITS    = 1   // 1 or 2, transmit side only
)(
    input  logic      clk,
    input  logic      resetn,
    input  logic      rxd,
    output logic      txd,
    output data_t     rx_data,
    output logic      rx_valid,
    input  logic      rx_ready,
    input  data_t     tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,
    output rx_event_t rx_event
);

    rx_shift_cmd_t rx_cmd;
    logic          frame_error;
    logic          overrun;

    uart_rx_ctrl #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .DATA_BITS   (DATA_BITS)
    ) u_rx_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .rxd        (rxd),
        .cmd        (rx_cmd),
        .frame_error(frame_error)
    );

    uart_rx_shift #(
        .DATA_BITS(DATA_BITS)
    ) u_rx_shift (
        .clk     (clk),
        .resetn  (resetn),
        .rxd     (rxd),
        .cmd     (rx_cmd),
        .rx_ready(rx_ready),
        .rx_data (rx_data),
        .rx_valid(rx_valid),
        .overrun (overrun)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .DATA_BITS   (DATA_BITS),
        .STOP_BITS   (STOP_BITS)
    ) u_tx (
        .clk     (clk),
        .resetn  (resetn),
        .tx_data (tx_data),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .txd     (txd)
    );

    assign rx_event = '{frame_error: frame_error, overrun: overrun};

endmodule

// File: test/uart_clk_gen.sv
// testbench clock and reset; 10 ns period, resetn low for the first 3 rising edges
module uart_clk_gen (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    always begin
        clk = 1'b0;
        #5;
        clk = 1'b1;
        #5;
    end

    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;  // same 1 ns offset as the other inputs
    end
endmodule

// File: test/uart_props.sv
// port checks bound into uart_top; each failure is also counted in fail_count
module uart_props
    import uart_pkg::*;
(
    input logic      clk,
    input logic      resetn,
    input logic      txd,
    input data_t     rx_data,
    input logic      rx_valid,
    input logic      rx_ready,
    input logic      tx_ready,
    input rx_event_t rx_event
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    task automatic report_failure(input string what);
        $error("assertion failed: %s", what);
        fail_count++;
    endtask

    held_word_stable: assert property (@(posedge clk) disable iff (!resetn)
        rx_valid && !rx_ready |=> $stable(rx_data))
        else report_failure("rx_data changed while the word was held");
    one_error_kind: assert property (@(posedge clk) disable iff (!resetn)
        !(rx_event.frame_error && rx_event.overrun))
        else report_failure("frame_error and overrun in the same cycle");
    idle_line_mark: assert property (@(posedge clk) disable iff (!resetn)
        tx_ready |-> txd == MARK)
        else report_failure("txd not at mark while tx_ready is high");
    reset_values: assert property (@(posedge clk)
        !resetn |=> !rx_valid && tx_ready)
        else report_failure("rx_valid or tx_ready off their reset value");

endmodule

// File: test/uart_tb.sv
// uart testbench; DUT at 8 clocks per bit, 8 data bits, 1 stop bit, rxd can loop back from txd
module uart_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CPB          = 8;
    localparam int FRAME_CYCLES = 10 * CPB;
    localparam int NUM_TESTS    = 8;
    localparam int LOOP_BYTES   = 6;
    localparam int WATCHDOG_NS  = NUM_TESTS * 12 * FRAME_CYCLES * 10 + 2000;

    typedef enum {M_RX, M_TX, M_FERR, M_OVR, M_GLITCH, M_LOOP} mode_t;
    typedef struct {
        string     name;
        data_t     data;
        mode_t     mode;
        data_t     exp_data;
        rx_event_t exp_event;  // {frame_error, overrun}, each expected once when set
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{"rx_a5",      8'ha5, M_RX,     8'ha5, 2'b00},
        '{"rx_3c",      8'h3c, M_RX,     8'h3c, 2'b00},
        '{"tx_81",      8'h81, M_TX,     8'h81, 2'b00},
        '{"tx_5a",      8'h5a, M_TX,     8'h5a, 2'b00},
        '{"ferr_e7",    8'he7, M_FERR,   8'h00, 2'b10},
        '{"overrun_c3", 8'hc3, M_OVR,    8'hc3, 2'b01},
        '{"glitch_96",  8'h96, M_GLITCH, 8'h96, 2'b00},
        '{"loopback",   8'h00, M_LOOP,   8'h00, 2'b00}
    };

    logic      clk, resetn, rxd, rxd_drv, loop_en, txd;
    logic      rx_valid, rx_ready, tx_valid, tx_ready;
    data_t     rx_data, tx_data;
    rx_event_t rx_event;
    data_t     rx_q[$];  // words taken from the receive stream
    int        errors = 0;
    int        fe_cnt = 0;
    int        ovr_cnt = 0;
    int        seed = 90541;

    uart_clk_gen clkgen (.clk(clk), .resetn(resetn));
    uart_top #(.CLKS_PER_BIT(CPB), .DATA_BITS(8), .STOP_BITS(1)) dut (.*);
    bind uart_top uart_props u_props (
        .clk(clk), .resetn(resetn), .txd(txd), .rx_data(rx_data),
        .rx_valid(rx_valid), .rx_ready(rx_ready), .tx_ready(tx_ready), .rx_event(rx_event)
    );

    assign rxd = loop_en ? txd : rxd_drv;

    // sampled at the falling edge, away from the input changes
    always @(negedge clk) begin
        if (resetn) begin
            if (rx_valid && rx_ready)
                rx_q.push_back(rx_data);
            fe_cnt  += int'(rx_event.frame_error);
            ovr_cnt += int'(rx_event.overrun);
        end
    end

    task automatic next_cycle(input int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // start bit, data lsb first, then the given stop level, a whole bit period each
    task automatic send_frame(input data_t d, input logic stop);
        logic [9:0] bits;
        bits = {stop, d, SPACE};
        for (int i = 0; i < 10; i++) begin
            rxd_drv = bits[i];
            next_cycle(CPB);
        end
        rxd_drv = MARK;
    endtask

    // returns just after the transfer edge
    task automatic push_tx(input data_t d);
        tx_data  = d;
        tx_valid = 1'b1;
        while (!tx_ready)
            next_cycle();
        next_cycle();
        tx_valid = 1'b0;
    endtask

    // the start bit begins at the transfer edge, so midpoints fall at fixed falling edges
    task automatic decode_txd(input string name, input data_t exp);
        logic [9:0] bits;
        int         busy;
        int         wait_ready;
        busy       = 0;
        wait_ready = 0;
        for (int i = 0; i < 10; i++) begin
            repeat (i == 0 ? CPB / 2 + 1 : CPB) @(negedge clk);
            bits[i] = txd;
            busy += int'(tx_ready);
        end
        while (!tx_ready) begin
            @(negedge clk);
            wait_ready++;
        end
        check_value({name, " data"}, int'(exp), int'(bits[8:1]));
        check_value({name, " stop and start"}, 2, int'({bits[9], bits[0]}));
        check_value({name, " ready during frame"}, 0, busy);
        check_value({name, " cycles to ready"}, CPB / 2, wait_ready);
        next_cycle();
    endtask

    task automatic run_test(input test_t t);
        data_t exp_q[$];
        data_t b;
        rx_q.delete();
        fe_cnt  = 0;
        ovr_cnt = 0;
        case (t.mode)
            M_RX, M_GLITCH: begin
                if (t.mode == M_GLITCH) begin
                    rxd_drv = SPACE;  // well short of half a bit
                    next_cycle(2);
                    rxd_drv = MARK;
                    next_cycle(2 * CPB);
                end
                send_frame(t.data, MARK);
                exp_q.push_back(t.exp_data);
            end
            M_TX: begin
                push_tx(t.data);
                decode_txd(t.name, t.exp_data);
            end
            M_FERR: send_frame(t.data, SPACE);
            M_OVR: begin
                rx_ready = 1'b0;
                send_frame(t.data, MARK);
                send_frame(~t.data, MARK);  // completes while the first word is held
                next_cycle(CPB);
                rx_ready = 1'b1;
                exp_q.push_back(t.exp_data);
            end
            M_LOOP: begin
                loop_en = 1'b1;
                for (int i = 0; i < LOOP_BYTES; i++) begin
                    b = data_t'($random(seed));
                    exp_q.push_back(b);
                    push_tx(b);
                end
            end
        endcase
        for (int n = 0; rx_q.size() < exp_q.size() && n < 2 * FRAME_CYCLES; n++)
            next_cycle();
        next_cycle(2 * CPB);  // room for stray words and pulses
        loop_en = 1'b0;
        check_value({t.name, " word count"}, exp_q.size(), rx_q.size());
        while (rx_q.size() > 0 && exp_q.size() > 0)
            check_value(t.name, int'(exp_q.pop_front()), int'(rx_q.pop_front()));
        check_value({t.name, " frame_error pulses"}, int'(t.exp_event.frame_error), fe_cnt);
        check_value({t.name, " overrun pulses"}, int'(t.exp_event.overrun), ovr_cnt);
    endtask

    initial begin
        rxd_drv  = MARK;
        loop_en  = 1'b0;
        rx_ready = 1'b1;
        tx_valid = 1'b0;
        tx_data  = '0;
        @(posedge resetn);
        next_cycle(2);
        foreach (tests[i])
            run_test(tests[i]);
        $display("checks failed: %0d, assertions failed: %0d", errors, dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: tb.f
hdl/uart_pkg.sv
hdl/uart_bit_timer.sv
hdl/uart_rx_ctrl.sv
hdl/uart_rx_shift.sv
hdl/uart_tx.sv
hdl/uart_top.sv
test/uart_clk_gen.sv
test/uart_props.sv
test/uart_tb.sv

// File: Makefile
# Verilator build and run of the uart testbench
TOP = uart_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
